// ==== Makefile ====
TOP := tb_yolo_read

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== compile.f ====
rtl/yolo_read_pkg.sv
rtl/bus_if.sv
rtl/yolo_read_config.sv
rtl/fetch_engine.sv
rtl/bus_arbiter.sv
rtl/read_sequencer.sv
rtl/yolo_read.sv
dv/yolo_read_props.sv
dv/tb_yolo_read.sv

// ==== dv/tb_yolo_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_yolo_read
   import yolo_read_pkg::*;
();

   localparam int N_VECT     = 4;
   localparam int BUF_ADDR_W = 6;
   localparam int N_TESTS    = 5;
   localparam int MAX_LEN    = 64;
   // every test fetches at most MAX_LEN words per peer, at worst about four cycles each
   localparam int TIMEOUT_CYCLES = N_TESTS * (N_VECT + 1) * MAX_LEN * 4 + 2000;

   logic                     clk;
   logic                     rst;
   logic                     clear;
   logic                     run;
   logic                     cfg_valid;
   logic [conf_addr_w-1:0]   cfg_addr;
   logic [addr_w-1:0]        cfg_wdata;
   logic                     bus_valid;
   logic [addr_w-1:0]        bus_addr;
   logic                     bus_ready = 1'b0;
   logic [data_w-1:0]        bus_rdata;
   logic [N_VECT*data_w-1:0] weights;
   logic [data_w-1:0]        bias;
   logic                     weight_valid;
   logic                     done;

   logic        stall_en = 1'b0;
   int          error_count;
   int          check_count;
   int          cycle_count;
   int          bus_cycles;
   // configuration of the current run, used for expected values
   logic [31:0] exp_ext, exp_offset, exp_len, exp_int_addr;
   logic [31:0] exp_iter, exp_start, exp_incr, exp_bias_ext, exp_bias_start;

   yolo_read #(
      .N_VECT     (N_VECT),
      .BUF_ADDR_W (BUF_ADDR_W)
   ) dut (
      .clk          (clk),
      .rst          (rst),
      .clear        (clear),
      .run          (run),
      .cfg_valid    (cfg_valid),
      .cfg_addr     (cfg_addr),
      .cfg_wdata    (cfg_wdata),
      .bus_valid    (bus_valid),
      .bus_addr     (bus_addr),
      .bus_ready    (bus_ready),
      .bus_rdata    (bus_rdata),
      .weights      (weights),
      .bias         (bias),
      .weight_valid (weight_valid),
      .done         (done)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // external memory contents, a bijection of the address
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
   endfunction

   assign bus_rdata = mem_word(bus_addr);

   // ready is low in about one cycle of four while stalling
   always @(posedge clk) begin
      bus_ready <= stall_en ? (($urandom % 32'd4) != 32'd0) : 1'b1;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: no result after %0d cycles, the DUT stopped responding",
                  TIMEOUT_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic check(input string what, input logic [31:0] got,
                        input logic [31:0] expected);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
      end
   endtask

   task automatic write_cfg(input conf_addr_t addr, input logic [31:0] data);
      @(posedge clk);
      cfg_valid <= 1'b1;
      cfg_addr  <= addr;
      cfg_wdata <= data;
      @(posedge clk);
      cfg_valid <= 1'b0;
   endtask

   task automatic configure(input logic [31:0] ext, input logic [31:0] offset,
                            input logic [31:0] len, input logic [31:0] int_addr,
                            input logic [31:0] iter, input logic [31:0] start,
                            input logic [31:0] incr, input logic [31:0] bias_ext,
                            input logic [31:0] bias_start);
      exp_ext        = ext;
      exp_offset     = offset;
      exp_len        = len;
      exp_int_addr   = int_addr;
      exp_iter       = iter;
      exp_start      = start;
      exp_incr       = incr;
      exp_bias_ext   = bias_ext;
      exp_bias_start = bias_start;
      write_cfg(CONF_EXT_ADDR, ext);
      write_cfg(CONF_OFFSET, offset);
      write_cfg(CONF_LEN, len);
      write_cfg(CONF_INT_ADDR, int_addr);
      write_cfg(CONF_ITER, iter);
      write_cfg(CONF_START, start);
      write_cfg(CONF_INCR, incr);
      write_cfg(CONF_BIAS_EXT_ADDR, bias_ext);
      write_cfg(CONF_BIAS_START, bias_start);
   endtask

   // run once and check every step until done
   task automatic run_and_check();
      int                    k;
      int                    cyc;
      int                    first_cyc;
      logic                  prev_wv;
      logic [BUF_ADDR_W-1:0] buf_addr;
      logic [BUF_ADDR_W-1:0] word_idx;
      k          = 0;
      cyc        = 0;
      first_cyc  = 0;
      prev_wv    = 1'b0;
      bus_cycles = 0;
      @(posedge clk);
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      @(negedge clk);
      check("done low after run", 32'(done), 32'd0);
      while (!done) begin
         if (bus_valid) begin
            bus_cycles++;
         end
         if (weight_valid) begin
            // steps come on back-to-back cycles
            if (k == 0) begin
               first_cyc = cyc;
            end else begin
               check($sformatf("weight_valid back to back at step %0d", k),
                     32'(cyc - first_cyc), 32'(k));
            end
            // buffer address back to the word index of the fetch
            buf_addr = BUF_ADDR_W'(exp_start + 32'(k) * exp_incr);
            word_idx = buf_addr - BUF_ADDR_W'(exp_int_addr);
            for (int i = 0; i < N_VECT; i++) begin
               check($sformatf("lane %0d step %0d", i, k), weights[i*data_w +: data_w],
                     mem_word(exp_ext + 32'(i) * exp_offset + 32'(word_idx)));
            end
            check($sformatf("bias step %0d", k), bias,
                  mem_word(exp_bias_ext + exp_bias_start));
            k++;
         end
         prev_wv = weight_valid;
         cyc++;
         @(negedge clk);
      end
      check("weight_valid count", 32'(k), exp_iter);
      if (exp_iter != 32'd0) begin
         check("weight_valid in cycle before done", 32'(prev_wv), 32'd1);
      end
   endtask

   task automatic hold_done(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check("done held", 32'(done), 32'd1);
         check("weight_valid after done", 32'(weight_valid), 32'd0);
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (error_count == errors_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, error_count - errors_before);
      end
   endtask

   task automatic test_basic();
      int errors_before;
      errors_before = error_count;
      configure(32'h1000, 32'h100, 32'd8, 32'd0, 32'd8, 32'd0, 32'd1, 32'h8000, 32'd3);
      run_and_check();
      // with ready always high every valid cycle completes a word
      check("bus requests", 32'(bus_cycles), 32'(N_VECT + 1) * exp_len);
      report_test("test 1 basic read", errors_before);
   endtask

   task automatic test_strided();
      int errors_before;
      errors_before = error_count;
      // write start 60 and read past 63 both wrap
      configure(32'h2_0000, 32'h40, 32'd64, 32'd60, 32'd24, 32'd2, 32'd3, 32'h3_0000, 32'd17);
      run_and_check();
      report_test("test 2 strided read", errors_before);
   endtask

   task automatic test_backpressure();
      int errors_before;
      errors_before = error_count;
      configure(32'h1000, 32'h100, 32'd8, 32'd0, 32'd8, 32'd0, 32'd1, 32'h8000, 32'd3);
      stall_en <= 1'b1;
      run_and_check();
      stall_en = 1'b0;
      // stalled requests stay valid for extra cycles
      check("bus stalled while valid", 32'(bus_cycles > 32'(N_VECT + 1) * exp_len), 32'd1);
      report_test("test 3 bus back-pressure", errors_before);
   endtask

   task automatic test_done_hold();
      int errors_before;
      errors_before = error_count;
      configure(32'h4000, 32'h10, 32'd4, 32'd0, 32'd4, 32'd0, 32'd1, 32'h5000, 32'd1);
      run_and_check();
      hold_done(6);
      exp_iter = 32'd0;
      write_cfg(CONF_ITER, 32'd0);
      hold_done(2);
      run_and_check();
      hold_done(4);
      report_test("test 4 done level", errors_before);
   endtask

   task automatic test_clear();
      int errors_before;
      errors_before = error_count;
      @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      configure_expect_zero();
      run_and_check();
      check("bus requests after clear", 32'(bus_cycles), 32'd0);
      hold_done(3);
      report_test("test 5 clear then run", errors_before);
   endtask

   task automatic configure_expect_zero();
      exp_ext        = '0;
      exp_offset     = '0;
      exp_len        = '0;
      exp_int_addr   = '0;
      exp_iter       = '0;
      exp_start      = '0;
      exp_incr       = '0;
      exp_bias_ext   = '0;
      exp_bias_start = '0;
   endtask

   initial begin
      void'($urandom(32'h569c));
      error_count = 0;
      check_count = 0;
      cycle_count = 0;
      rst         = 1'b1;
      clear       = 1'b0;
      run         = 1'b0;
      cfg_valid   = 1'b0;
      cfg_addr    = '0;
      cfg_wdata   = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      test_basic();
      test_strided();
      test_backpressure();
      test_done_hold();
      test_clear();
      $display("tests: %0d, checks: %0d, errors: %0d", N_TESTS, check_count, error_count);
      if (error_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/yolo_read_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module yolo_read_props
   import yolo_read_pkg::*;
#(
   parameter int N_PEERS = 5
) (
   input logic               clk,
   input logic               rst,
   input logic [N_PEERS-1:0] req,
   input logic [N_PEERS-1:0] grant,
   input logic               bus_valid,
   input logic [addr_w-1:0]  bus_addr,
   input logic               bus_ready,
   input logic               done,
   input logic               weight_valid
);

   // one peer on the bus at a time, and only a peer that requests
   grant_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(grant) && ((grant & ~req) == '0))
      else $error("bad grant %b for requests %b", grant, req);

   // a stalled request keeps its address
   addr_stable: assert property (@(posedge clk) disable iff (rst)
      (bus_valid && !bus_ready) |=> (bus_valid && $stable(bus_addr)))
      else $error("bus request changed while stalled");

   done_no_valid: assert property (@(posedge clk) disable iff (rst) !(done && weight_valid))
      else $error("done and weight_valid high together");

endmodule

bind bus_arbiter yolo_read_props #(
   .N_PEERS (N_VECT + 1)
) u_arb_props (
   .clk          (clk),
   .rst          (rst),
   .req          (req),
   .grant        (grant),
   .bus_valid    (bus_valid),
   .bus_addr     (bus_addr),
   .bus_ready    (bus_ready),
   .done         (1'b0),
   .weight_valid (1'b0)
);

// top instance watches only the output handshake
bind yolo_read yolo_read_props #(
   .N_PEERS (1)
) u_top_props (
   .clk          (clk),
   .rst          (rst),
   .req          (1'b0),
   .grant        (1'b0),
   .bus_valid    (1'b0),
   .bus_addr     ('0),
   .bus_ready    (1'b1),
   .done         (done),
   .weight_valid (weight_valid)
);

`default_nettype wire

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
   import yolo_read_pkg::*;
#(
   parameter int N_VECT = 4
) (
   bus_if.arbiter             peers [N_VECT+1],
   input  logic               clk,
   input  logic               rst,
   output logic               bus_valid,
   output logic [addr_w-1:0]  bus_addr,
   input  logic               bus_ready,
   input  logic [data_w-1:0]  bus_rdata
);

   localparam int N_PEERS = N_VECT + 1;
   localparam int IDX_W   = $clog2(N_PEERS);

   logic [N_PEERS-1:0] req;
   logic [addr_w-1:0]  req_addr [N_PEERS];
   logic [N_PEERS-1:0] grant;
   logic [IDX_W-1:0]   ptr;
   logic [IDX_W-1:0]   sel;
   logic               locked;

   for (genvar i = 0; i < N_PEERS; i++) begin : g_peer
      assign req[i]         = peers[i].valid;
      assign req_addr[i]    = peers[i].addr;
      assign grant[i]       = bus_valid && (sel == IDX_W'(i));
      assign peers[i].ready = grant[i] && bus_ready;
      assign peers[i].rdata = grant[i] ? bus_rdata : '0;
   end

   // first requester after the last granted peer, unless locked
   always_comb begin
      int   idx;
      logic found;
      idx   = 0;
      found = 1'b0;
      sel   = ptr;
      if (!locked) begin
         for (int k = 1; k <= N_PEERS; k++) begin
            idx = int'(ptr) + k;
            if (idx >= N_PEERS) begin
               idx = idx - N_PEERS;
            end
            if (!found && req[idx]) begin
               sel   = IDX_W'(idx);
               found = 1'b1;
            end
         end
      end
   end

   assign bus_valid = locked ? req[ptr] : |req;
   assign bus_addr  = req_addr[sel];

   // hold the grant while the bus stalls
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ptr    <= IDX_W'(N_PEERS - 1);
         locked <= 1'b0;
      end else if (bus_valid) begin
         ptr    <= sel;
         locked <= !bus_ready;
      end else begin
         locked <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one word read request on the shared data bus
interface bus_if
   import yolo_read_pkg::*;
();

   logic              valid;
   logic [addr_w-1:0] addr;
   logic              ready;
   logic [data_w-1:0] rdata;

   // peer side holds valid and addr until ready
   modport requester (output valid, output addr, input ready, input rdata);

   modport arbiter (input valid, input addr, output ready, output rdata);

endinterface

`default_nettype wire

// ==== rtl/fetch_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_engine
   import yolo_read_pkg::*;
#(
   parameter int BUF_ADDR_W = 6
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  logic [addr_w-1:0]     base,
   input  logic [BUF_ADDR_W:0]   len,
   input  logic [BUF_ADDR_W-1:0] int_addr,
   input  logic [BUF_ADDR_W-1:0] rd_addr,
   bus_if.requester              bus,
   output logic [data_w-1:0]     rd_data,
   output logic                  fetch_done
);

   localparam int DEPTH = 1 << BUF_ADDR_W;

   logic [data_w-1:0]     mem [DEPTH];
   fetch_state_t          state;
   logic [BUF_ADDR_W:0]   count;
   logic [BUF_ADDR_W-1:0] wr_addr;
   logic                  xfer;

   // base and len come from the shadows, already loaded once busy
   assign bus.valid  = (state == FETCH_BUSY) && (count != len);
   assign bus.addr   = base + addr_w'(count);
   assign xfer       = bus.valid && bus.ready;
   assign fetch_done = (state == FETCH_DONE);

   // buffer address wraps
   assign wr_addr = int_addr + count[BUF_ADDR_W-1:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= FETCH_IDLE;
         count <= '0;
      end else if (run) begin
         // restart from the new shadow values
         state <= FETCH_BUSY;
         count <= '0;
      end else begin
         case (state)
            FETCH_BUSY: begin
               if (count == len) begin
                  state <= FETCH_DONE;
               end else if (xfer) begin
                  count <= count + 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

   // write on the completion edge, registered read port
   always_ff @(posedge clk) begin
      if (xfer) begin
         mem[wr_addr] <= bus.rdata;
      end
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== rtl/read_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_sequencer
   import yolo_read_pkg::*;
#(
   parameter int BUF_ADDR_W = 6
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  logic                  all_fetched,
   input  logic [BUF_ADDR_W:0]   iter,
   input  logic [BUF_ADDR_W-1:0] start,
   input  logic [BUF_ADDR_W-1:0] incr,
   output logic [BUF_ADDR_W-1:0] rd_addr,
   output logic                  weight_valid,
   output logic                  done
);

   seq_state_t          state;
   logic [BUF_ADDR_W:0] step;
   logic                rd_en;

   // step 0 is read in the first cycle all_fetched is seen
   assign rd_en = ((state == SEQ_WAIT) && all_fetched && (iter != '0)) ||
                  (state == SEQ_READ);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state        <= SEQ_IDLE;
         step         <= '0;
         rd_addr      <= '0;
         weight_valid <= 1'b0;
         done         <= 1'b0;
      end else begin
         // buffer data is out one cycle after its address
         weight_valid <= rd_en && !run;
         done         <= (state == SEQ_DONE) && !run;
         if (run) begin
            state <= SEQ_WAIT;
            step  <= '0;
         end else begin
            case (state)
               SEQ_WAIT: begin
                  if (!all_fetched) begin
                     rd_addr <= start;
                  end else if (iter == '0) begin
                     state <= SEQ_DONE;
                  end else begin
                     rd_addr <= rd_addr + incr;
                     step    <= 1;
                     state   <= (iter == 1) ? SEQ_DONE : SEQ_READ;
                  end
               end
               SEQ_READ: begin
                  rd_addr <= rd_addr + incr;
                  step    <= step + 1'b1;
                  if (step == iter - 1'b1) begin
                     state <= SEQ_DONE;
                  end
               end
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/yolo_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module yolo_read
   import yolo_read_pkg::*;
#(
   parameter int N_VECT     = 4,
   parameter int BUF_ADDR_W = 6
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       clear,
   input  logic                       run,
   input  logic                       cfg_valid,
   input  logic [conf_addr_w-1:0]     cfg_addr,
   input  logic [addr_w-1:0]          cfg_wdata,
   output logic                       bus_valid,
   output logic [addr_w-1:0]          bus_addr,
   input  logic                       bus_ready,
   input  logic [data_w-1:0]          bus_rdata,
   output logic [N_VECT*data_w-1:0]   weights,
   output logic [data_w-1:0]          bias,
   output logic                       weight_valid,
   output logic                       done
);

   logic [N_VECT-1:0][addr_w-1:0] lane_base;
   logic [BUF_ADDR_W:0]           len;
   logic [BUF_ADDR_W-1:0]         int_addr;
   logic [BUF_ADDR_W:0]           iter;
   logic [BUF_ADDR_W-1:0]         start;
   logic [BUF_ADDR_W-1:0]         incr;
   logic [addr_w-1:0]             bias_base;
   logic [BUF_ADDR_W-1:0]         bias_start;
   logic [BUF_ADDR_W-1:0]         rd_addr;
   logic [N_VECT:0]               fetch_done;
   logic                          all_fetched;

   // index N_VECT is the bias peer
   bus_if peer_bus [N_VECT+1] ();

   yolo_read_config #(
      .N_VECT     (N_VECT),
      .BUF_ADDR_W (BUF_ADDR_W)
   ) u_config (
      .clk        (clk),
      .rst        (rst),
      .clear      (clear),
      .run        (run),
      .cfg_valid  (cfg_valid),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .lane_base  (lane_base),
      .len        (len),
      .int_addr   (int_addr),
      .iter       (iter),
      .start      (start),
      .incr       (incr),
      .bias_base  (bias_base),
      .bias_start (bias_start)
   );

   for (genvar i = 0; i < N_VECT; i++) begin : g_lane
      fetch_engine #(
         .BUF_ADDR_W (BUF_ADDR_W)
      ) u_fetch (
         .clk        (clk),
         .rst        (rst),
         .run        (run),
         .base       (lane_base[i]),
         .len        (len),
         .int_addr   (int_addr),
         .rd_addr    (rd_addr),
         .bus        (peer_bus[i]),
         .rd_data    (weights[i*data_w +: data_w]),
         .fetch_done (fetch_done[i])
      );
   end

   // bias buffer filled from address 0, read at a fixed word
   fetch_engine #(
      .BUF_ADDR_W (BUF_ADDR_W)
   ) u_bias_fetch (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .base       (bias_base),
      .len        (len),
      .int_addr   ('0),
      .rd_addr    (bias_start),
      .bus        (peer_bus[N_VECT]),
      .rd_data    (bias),
      .fetch_done (fetch_done[N_VECT])
   );

   assign all_fetched = &fetch_done;

   bus_arbiter #(
      .N_VECT (N_VECT)
   ) u_arbiter (
      .peers     (peer_bus),
      .clk       (clk),
      .rst       (rst),
      .bus_valid (bus_valid),
      .bus_addr  (bus_addr),
      .bus_ready (bus_ready),
      .bus_rdata (bus_rdata)
   );

   read_sequencer #(
      .BUF_ADDR_W (BUF_ADDR_W)
   ) u_sequencer (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .all_fetched  (all_fetched),
      .iter         (iter),
      .start        (start),
      .incr         (incr),
      .rd_addr      (rd_addr),
      .weight_valid (weight_valid),
      .done         (done)
   );

endmodule

`default_nettype wire

// ==== rtl/yolo_read_config.sv ====
`timescale 1ns/1ps
`default_nettype none

module yolo_read_config
   import yolo_read_pkg::*;
#(
   parameter int N_VECT     = 4,
   parameter int BUF_ADDR_W = 6
) (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             clear,
   input  logic                             run,
   input  logic                             cfg_valid,
   input  logic [conf_addr_w-1:0]           cfg_addr,
   input  logic [addr_w-1:0]                cfg_wdata,
   output logic [N_VECT-1:0][addr_w-1:0]    lane_base,
   output logic [BUF_ADDR_W:0]              len,
   output logic [BUF_ADDR_W-1:0]            int_addr,
   output logic [BUF_ADDR_W:0]              iter,
   output logic [BUF_ADDR_W-1:0]            start,
   output logic [BUF_ADDR_W-1:0]            incr,
   output logic [addr_w-1:0]                bias_base,
   output logic [BUF_ADDR_W-1:0]            bias_start
);

   // working registers written by the cpu
   logic [addr_w-1:0]              ext_addr_r;
   logic [addr_w-1:0]              offset_r;
   logic [BUF_ADDR_W:0]            len_r;
   logic [BUF_ADDR_W-1:0]          int_addr_r;
   logic [BUF_ADDR_W:0]            iter_r;
   logic [BUF_ADDR_W-1:0]          start_r;
   logic [BUF_ADDR_W-1:0]          incr_r;
   logic [addr_w-1:0]              bias_ext_addr_r;
   logic [BUF_ADDR_W-1:0]          bias_start_r;
   logic [N_VECT-1:0][addr_w-1:0]  base_calc;

   always_ff @(posedge clk or posedge rst) begin
      if (rst || clear) begin
         ext_addr_r      <= '0;
         offset_r        <= '0;
         len_r           <= '0;
         int_addr_r      <= '0;
         iter_r          <= '0;
         start_r         <= '0;
         incr_r          <= '0;
         bias_ext_addr_r <= '0;
         bias_start_r    <= '0;
      end else if (cfg_valid) begin
         case (conf_addr_t'(cfg_addr))
            CONF_EXT_ADDR:      ext_addr_r      <= cfg_wdata;
            CONF_OFFSET:        offset_r        <= cfg_wdata;
            CONF_LEN:           len_r           <= cfg_wdata[BUF_ADDR_W:0];
            CONF_INT_ADDR:      int_addr_r      <= cfg_wdata[BUF_ADDR_W-1:0];
            CONF_ITER:          iter_r          <= cfg_wdata[BUF_ADDR_W:0];
            CONF_START:         start_r         <= cfg_wdata[BUF_ADDR_W-1:0];
            CONF_INCR:          incr_r          <= cfg_wdata[BUF_ADDR_W-1:0];
            CONF_BIAS_EXT_ADDR: bias_ext_addr_r <= cfg_wdata;
            CONF_BIAS_START:    bias_start_r    <= cfg_wdata[BUF_ADDR_W-1:0];
            default: ;
         endcase
      end
   end

   // lane i base is ext_addr plus i times offset, as a running sum
   always_comb begin
      logic [addr_w-1:0] acc;
      acc = ext_addr_r;
      for (int i = 0; i < N_VECT; i++) begin
         base_calc[i] = acc;
         acc          = acc + offset_r;
      end
   end

   // shadows hold the values of the current run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         lane_base  <= '0;
         len        <= '0;
         int_addr   <= '0;
         iter       <= '0;
         start      <= '0;
         incr       <= '0;
         bias_base  <= '0;
         bias_start <= '0;
      end else if (run) begin
         lane_base  <= base_calc;
         len        <= len_r;
         int_addr   <= int_addr_r;
         iter       <= iter_r;
         start      <= start_r;
         incr       <= incr_r;
         bias_base  <= bias_ext_addr_r;
         bias_start <= bias_start_r;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/yolo_read_pkg.sv ====
`default_nettype none

package yolo_read_pkg;

   // external bus and datapath widths
   localparam int addr_w      = 32;
   localparam int data_w      = 32;
   localparam int conf_addr_w = 4;

   // config register map
   typedef enum logic [conf_addr_w-1:0] {
      CONF_EXT_ADDR      = 4'd0,
      CONF_OFFSET        = 4'd1,
      CONF_LEN           = 4'd2,
      CONF_INT_ADDR      = 4'd3,
      CONF_ITER          = 4'd4,
      CONF_START         = 4'd5,
      CONF_INCR          = 4'd6,
      CONF_BIAS_EXT_ADDR = 4'd7,
      CONF_BIAS_START    = 4'd8
   } conf_addr_t;

   typedef enum logic [1:0] {
      FETCH_IDLE,
      FETCH_BUSY,
      FETCH_DONE
   } fetch_state_t;

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_WAIT,
      SEQ_READ,
      SEQ_DONE
   } seq_state_t;

endpackage

`default_nettype wire
